//--- verification/zports_stim.txt
// op addr value, hex: wr rd vid beep sdwr sdrd ld ldcpu page cfg spi
// ldcpu addr = cpu idx, loader idx and value = cpu data, loader data; cfg addr = sysconf, memconf
page 0000 00020500
cfg  0004 01000000
spi  0000 110
rd   00af 40
rd   00af 00
wr   12af 3c
wr   13af 81
rd   12af 3c
rd   13af 81
page 0000 813c0500
wr   20af 04
cfg  0404 010f0000
wr   7ffd d7
page 0000 1f3c0500
cfg  0405 010f0000
wr   21af 40
wr   7ffd c3
page 0000 033c0500
wr   21af c0
wr   7ffd 65
page 0000 2d3c0500
wr   7ffd 02
page 0000 023c0500
wr   21af 00
wr   7ffd 21
wr   7ffd 17
page 0000 013c0500
cfg  0400 010f0000
ld   11af 9a
ldcpu 102a 5503
ld   15af 1b
page 0000 013c9a55
cfg  0400 030f1b00
wr   0077 0a
spi  0000 100
wr   0077 00
spi  0000 010
rd   0077 00
sdwr 0057 a5
sdrd 0057 c6
vid  00af 12
beep 00fe 00
rd   00fe f5

//--- zports.f
logic/zports_pkg.sv
logic/port_decoder.sv
logic/reg_bus_arbiter.sv
logic/xt_regfile.sv
logic/sd_port.sv
logic/port_read_mux.sv
logic/zports.sv
verification/zports_props.sv
verification/zports_tb.sv

//--- Bender.yml
package:
  name: zports

sources:
  - logic/zports_pkg.sv
  - logic/port_decoder.sv
  - logic/reg_bus_arbiter.sv
  - logic/xt_regfile.sv
  - logic/sd_port.sv
  - logic/port_read_mux.sv
  - logic/zports.sv
  - target: test
    files:
      - verification/zports_props.sv
      - verification/zports_tb.sv

//--- verification/zports_tb.sv
// testbench for the I/O port block with clock, reset, stimulus reader, compare tasks and timeout
`default_nettype none

module zports_tb import zports_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  logic       clk = 1'b0;
  logic       rst;
  port_addr_t a;
  byte_t      din;
  logic       iord;
  logic       iord_s;
  logic       iowr_s;
  logic       tape_read;
  logic [4:0] keys_in;
  byte_t      sd_dataout;
  logic       loader_req;
  reg_wr_t    loader_wr;
  logic       loader_ack;
  byte_t      dout;
  logic       dataout;
  logic       porthit;
  logic       beeper_wr;
  xt_page_t   xt_page;
  sys_cfg_t   sys_cfg;
  video_wr_t  video_wr;
  spi_ctrl_t  spi;
  logic       sd_start;
  byte_t      sd_datain;

  int seed = 32'h59a8;
  int cycle_cnt = 0;
  int timeout_limit = 0;  // set once the stimulus length is known

  zports dut (.*);

  always #20 clk = ~clk;

  task automatic stop_run();
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp)
    begin
      $display("** Error %s: got %h, expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("** Error %s: got %h, expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_page(input xt_page_t got, input xt_page_t exp);
    if (got !== exp)
    begin
      $display("** Error xt_page: got %h, expected %h", got, exp);
      stop_run();
    end
  endtask

  task automatic check_cfg(input sys_cfg_t got, input sys_cfg_t exp);
    if (got !== exp)
    begin
      $display("** Error sys_cfg: got %h, expected %h", got, exp);
      stop_run();
    end
  endtask

  task automatic check_spi(input spi_ctrl_t got, input spi_ctrl_t exp);
    if (got !== exp)
    begin
      $display("** Error spi: got %h, expected %h", got, exp);
      stop_run();
    end
  endtask

  // idx and data only matter while valid is expected
  task automatic check_video(input video_wr_t got, input video_wr_t exp);
    if (got.valid !== exp.valid || (exp.valid && got !== exp))
    begin
      $display("** Error video_wr: got %h, expected %h", got, exp);
      stop_run();
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic go_idle();
    logic [31:0] rnd;
    rnd = $random(seed);
    a = 16'h0000;
    din = rnd[7:0];  // don't care between cycles
    iord = 1'b0;
    iord_s = 1'b0;
    iowr_s = 1'b0;
    loader_req = 1'b0;
    loader_wr = rnd[24:8];
  endtask

  // one io write cycle with strobe checks before the next edge
  task automatic io_write(input port_addr_t addr, input byte_t data, input string kind);
    a = addr;
    din = data;
    iowr_s = 1'b1;
    @(negedge clk);
    check_bit("porthit", porthit, 1'b1);
    if (kind == "vid")
      check_video(video_wr, '{valid: 1'b1, idx: xt_reg_e'(addr[15:8]), data: data});
    else if (kind == "beep")
      check_bit("beeper_wr", beeper_wr, 1'b1);
    else if (kind == "sdwr")
    begin
      check_bit("sd_start", sd_start, 1'b1);
      check_byte("sd_datain", sd_datain, data);
    end
    next_cycle();
    go_idle();
    if (kind == "vid" || kind == "beep" || kind == "sdwr")
    begin
      @(negedge clk);
      check_video(video_wr, '{valid: 1'b0, idx: VCONF, data: 8'h00});  // strobe gone
      check_bit("beeper_wr", beeper_wr, 1'b0);
      check_bit("sd_start", sd_start, 1'b0);
      next_cycle();
    end
  endtask

  task automatic io_read(input port_addr_t addr, input byte_t exp, input logic sd_rd);
    a = addr;
    iord = 1'b1;
    iord_s = 1'b1;
    if (sd_rd)
      sd_dataout = exp;
    @(negedge clk);
    check_byte("dout", dout, exp);
    check_bit("porthit", porthit, 1'b1);
    check_bit("dataout", dataout, 1'b1);
    if (sd_rd)
    begin
      check_bit("sd_start", sd_start, 1'b1);
      check_byte("sd_datain", sd_datain, 8'hFF);
    end
    next_cycle();
    go_idle();
  endtask

  task automatic loader_write(input byte_t idx, input byte_t data);
    logic acked;
    acked = 1'b0;
    loader_req = 1'b1;
    loader_wr.idx = xt_reg_e'(idx);
    loader_wr.data = data;
    while (!acked)
    begin
      @(negedge clk);
      acked = loader_ack;
      next_cycle();
    end
    go_idle();
  endtask

  // loader held across a CPU #nnAF write
  task automatic loader_under_cpu(input logic [15:0] idx, input logic [15:0] data);
    a = {idx[15:8], 8'hAF};
    din = data[15:8];
    iowr_s = 1'b1;
    loader_req = 1'b1;
    loader_wr.idx = xt_reg_e'(idx[7:0]);
    loader_wr.data = data[7:0];
    @(negedge clk);
    check_bit("loader_ack", loader_ack, 1'b0);
    next_cycle();
    iowr_s = 1'b0;
    a = 16'h0000;
    @(negedge clk);
    check_bit("loader_ack", loader_ack, 1'b1);
    next_cycle();
    go_idle();
  endtask

  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (timeout_limit > 0 && cycle_cnt > timeout_limit)
    begin
      $display("timeout after %0d cycles, stimulus did not finish", cycle_cnt);
      stop_run();
    end
  end

  initial
  begin
    int          fd;
    int          n_lines;
    int          n_fields;
    int          assert_fails;
    string       line;
    string       op;
    logic [15:0] addr;
    logic [31:0] val;

    rst = 1'b1;
    sd_dataout = 8'h00;
    tape_read = 1'b1;
    keys_in = 5'h15;  // #FE reads F5
    go_idle();

    fd = $fopen("verification/zports_stim.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open the stimulus file");
      stop_run();
    end
    n_lines = 0;
    while ($fgets(line, fd) != 0)
      n_lines = n_lines + 1;
    $fclose(fd);
    timeout_limit = 20 * n_lines + 50;
    fd = $fopen("verification/zports_stim.txt", "r");

    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;

    while ($fgets(line, fd) != 0)
    begin
      if (line.len() < 2 || line.substr(0, 1) == "//")
        continue;
      n_fields = $sscanf(line, "%s %h %h", op, addr, val);
      if (n_fields != 3)
      begin
        $display("malformed stimulus line: %s", line);
        stop_run();
      end
      if (op == "wr" || op == "vid" || op == "beep" || op == "sdwr")
        io_write(addr, val[7:0], op);
      else if (op == "rd" || op == "sdrd")
        io_read(addr, val[7:0], op == "sdrd");
      else if (op == "ld")
        loader_write(addr[15:8], val[7:0]);
      else if (op == "ldcpu")
        loader_under_cpu(addr, val[15:0]);
      else if (op == "page" || op == "cfg" || op == "spi")
      begin
        @(negedge clk);
        check_bit("porthit", porthit, 1'b0);  // bus idle on port 00
        check_bit("dataout", dataout, 1'b0);
        if (op == "page")
          check_page(xt_page, xt_page_t'(val));
        else if (op == "cfg")
          check_cfg(sys_cfg, '{sysconf: addr[15:8], memconf: addr[7:0], intmask: val[31:24],
                               cacheconf: val[19:16], fmaddr: val[12:8], dmawpdev: val[1:0]});
        else
          check_spi(spi, '{sd_cs_n: val[8], sd2_cs_n: val[4], spi_mode: val[0]});
        next_cycle();
      end
      else
      begin
        $display("unknown operation in stimulus file: %s", op);
        stop_run();
      end
    end
    $fclose(fd);

    repeat (2) next_cycle();
    assert_fails = dut.u_arbiter.u_props.fail_cnt + dut.u_regfile.u_props.fail_cnt;
    if (assert_fails == 0)
    begin
      $display("All tests passed");
      $finish;
    end
    else
    begin
      $display("%0d assertion failures during the run", assert_fails);
      stop_run();
    end
  end

endmodule

`default_nettype wire

//--- verification/zports_props.sv
// bound assertions on bus priority, loader acknowledge, video strobe width and loader wait
`default_nettype none

module zports_props import zports_pkg::*; (
  input logic               clk,
  input logic               rst,
  input reg_wr_t            cpu_wr,
  input reg_wr_t            loader_wr,
  input reg_wr_t            bus_wr,
  input logic               loader_ack,
  input logic [STALL_W-1:0] stall_cnt,
  input video_wr_t          video_wr
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_cnt = 0;

  cpu_first: assert property (@(posedge clk) disable iff (rst)
    cpu_wr.valid |-> bus_wr == cpu_wr)
  else
  begin
    $error("CPU register write not on the bus");
    fail_cnt++;
  end

  // an acked loader write is the one on the bus
  ack_vs_cpu: assert property (@(posedge clk) disable iff (rst)
    loader_ack |-> bus_wr.valid && bus_wr.idx == loader_wr.idx
                   && bus_wr.data == loader_wr.data)
  else
  begin
    $error("loader acknowledged while its write was not on the bus");
    fail_cnt++;
  end

  video_one_cycle: assert property (@(posedge clk) disable iff (rst)
    video_wr.valid |=> !video_wr.valid)
  else
  begin
    $error("video write strobe held longer than one cycle");
    fail_cnt++;
  end

  loader_wait: assert property (@(posedge clk) disable iff (rst) stall_cnt < 4)
  else
  begin
    $error("loader stalled for four cycles or more");
    fail_cnt++;
  end

endmodule

bind reg_bus_arbiter zports_props u_props (
  .clk(clk), .rst(rst), .cpu_wr(cpu_wr), .loader_wr(loader_wr), .bus_wr(bus_wr),
  .loader_ack(loader_ack), .stall_cnt(stall_cnt), .video_wr('0)
);

bind xt_regfile zports_props u_props (
  .clk(clk), .rst(rst), .cpu_wr('0), .loader_wr('0), .bus_wr(bus_wr),
  .loader_ack(1'b0), .stall_cnt('0), .video_wr(video_wr)
);

`default_nettype wire

//--- logic/zports.sv
// I/O port block top level, decoder, arbiter, register file, SD port and read mux
`default_nettype none

module zports import zports_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  port_addr_t a,
  input  byte_t      din,
  input  logic       iord,
  input  logic       iord_s,
  input  logic       iowr_s,
  input  logic       tape_read,
  input  logic [4:0] keys_in,
  input  byte_t      sd_dataout,
  input  logic       loader_req,
  input  reg_wr_t    loader_wr,
  output logic       loader_ack,
  output byte_t      dout,
  output logic       dataout,
  output logic       porthit,
  output logic       beeper_wr,
  output xt_page_t   xt_page,
  output sys_cfg_t   sys_cfg,
  output video_wr_t  video_wr,
  output spi_ctrl_t  spi,
  output logic       sd_start,
  output byte_t      sd_datain
);

  port_sel_e port_sel;
  reg_wr_t   cpu_wr;
  reg_wr_t   bus_wr;
  logic      p7ffd_try;

  port_decoder u_decoder (
    .a(a), .din(din), .iord_s(iord_s), .iowr_s(iowr_s), .port_sel(port_sel),
    .cpu_wr(cpu_wr), .p7ffd_try(p7ffd_try), .beeper_wr(beeper_wr), .porthit(porthit)
  );

  reg_bus_arbiter u_arbiter (
    .clk(clk), .rst(rst), .cpu_wr(cpu_wr), .loader_req(loader_req),
    .loader_wr(loader_wr), .bus_wr(bus_wr), .loader_ack(loader_ack)
  );

  xt_regfile u_regfile (
    .clk(clk), .rst(rst), .bus_wr(bus_wr), .p7ffd_try(p7ffd_try), .din(din),
    .xt_page(xt_page), .sys_cfg(sys_cfg), .video_wr(video_wr)
  );

  sd_port u_sd (
    .clk(clk), .rst(rst), .port_sel(port_sel), .iord_s(iord_s), .iowr_s(iowr_s),
    .din(din), .spi(spi), .sd_start(sd_start), .sd_datain(sd_datain)
  );

  port_read_mux u_read_mux (
    .clk(clk), .port_sel(port_sel), .a(a), .iord_s(iord_s), .keys_in(keys_in),
    .tape_read(tape_read), .xt_page(xt_page), .sd_dataout(sd_dataout), .dout(dout)
  );

  assign dataout = porthit && iord;  // drive the CPU data bus

endmodule

`default_nettype wire

//--- logic/port_read_mux.sv
// port read-data selection and the power-up status flag
`default_nettype none

module port_read_mux import zports_pkg::*; (
  input  logic       clk,
  input  port_sel_e  port_sel,
  input  port_addr_t a,
  input  logic       iord_s,
  input  logic [4:0] keys_in,
  input  logic       tape_read,
  input  xt_page_t   xt_page,
  input  byte_t      sd_dataout,
  output byte_t      dout
);

  xt_reg_e hoa;
  logic    xstat_rd;
  logic    pwr_up = 1'b1;  // set at configuration, cleared by first status read

  assign hoa      = xt_reg_e'(a[15:8]);
  assign xstat_rd = iord_s && (port_sel == PORT_XT) && (hoa == XSTAT);

  always_ff @(posedge clk)
  begin
    if (xstat_rd)
      pwr_up <= 1'b0;
  end

  always_comb
  begin
    case (port_sel)
      PORT_FE:
        dout = {1'b1, tape_read, 1'b1, keys_in};
      PORT_XT:
      begin
        case (hoa)
          XSTAT:    dout = {1'b0, pwr_up, 6'b000000};
          RAMPAGE2: dout = xt_page.page2;
          RAMPAGE3: dout = xt_page.page3;
          default:  dout = 8'hFF;
        endcase
      end
      PORT_SDCFG:
        dout = 8'h00;  // card present, not write protected
      PORT_SDDAT:
        dout = sd_dataout;
      default:
        dout = 8'hFF;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/sd_port.sv
// SD card chip-select register and SPI start and data strobes
`default_nettype none

module sd_port import zports_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  port_sel_e port_sel,
  input  logic      iord_s,
  input  logic      iowr_s,
  input  byte_t     din,
  output spi_ctrl_t spi,
  output logic      sd_start,
  output byte_t     sd_datain
);

  logic sdcfg_wr;
  logic sddat_wr;

  assign sdcfg_wr = iowr_s && (port_sel == PORT_SDCFG);
  assign sddat_wr = iowr_s && (port_sel == PORT_SDDAT);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      spi.sd_cs_n  <= 1'b1;  // both cards deselected
      spi.sd2_cs_n <= 1'b1;
      spi.spi_mode <= 1'b0;
    end
    else if (sdcfg_wr)
    begin
      spi.sd_cs_n  <= din[1];
      spi.sd2_cs_n <= ~din[3];
    end
  end

  // any #57 access starts one byte exchange
  assign sd_start  = (iord_s || iowr_s) && (port_sel == PORT_SDDAT);
  assign sd_datain = sddat_wr ? din : 8'hFF;  // reads clock out ones

endmodule

`default_nettype wire

//--- logic/xt_regfile.sv
// extended registers, 7FFD paging with lock modes, video write strobe
`default_nettype none

module xt_regfile import zports_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  reg_wr_t   bus_wr,
  input  logic      p7ffd_try,
  input  byte_t     din,
  output xt_page_t  xt_page,
  output sys_cfg_t  sys_cfg,
  output video_wr_t video_wr
);

  xt_page_t page_q;
  sys_cfg_t cfg_q;
  logic     lock48;
  logic     lock_mode3;
  logic     lock128;
  logic     p7ffd_wr;

  function automatic logic is_video(input xt_reg_e idx);
    case (idx)
      VCONF, VPAGE, GXOFFSL, GXOFFSH, GYOFFSL, GYOFFSH, TSCONF, PALSEL, XBORDER,
      T0XOFFSL, T0XOFFSH, T0YOFFSL, T0YOFFSH, T1XOFFSL, T1XOFFSH, T1YOFFSL, T1YOFFSH,
      TMPAGE, T0GPAGE, T1GPAGE, SGPAGE, HSINT, VSINTL, VSINTH:
        is_video = 1'b1;
      default:
        is_video = 1'b0;
    endcase
  endfunction

  // mode 2 falls back to mode 0 here
  assign lock_mode3 = (cfg_q.memconf[7:6] == MEMCONF_LOCK_MODE3);
  assign lock128    = !lock_mode3 && cfg_q.memconf[6];
  assign p7ffd_wr   = p7ffd_try && !lock48;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      page_q <= RST_PAGE;
      cfg_q  <= RST_SYS_CFG;
    end
    else
    begin
      if (bus_wr.valid)
      begin
        case (bus_wr.idx)
          RAMPAGE0:  page_q.page0 <= bus_wr.data;
          RAMPAGE1:  page_q.page1 <= bus_wr.data;
          RAMPAGE2:  page_q.page2 <= bus_wr.data;
          RAMPAGE3:  page_q.page3 <= bus_wr.data;
          FMADDR:    cfg_q.fmaddr <= bus_wr.data[4:0];
          SYSCONF:
          begin
            cfg_q.sysconf   <= bus_wr.data;
            cfg_q.cacheconf <= {4{bus_wr.data[2]}};  // cache follows turbo bit
          end
          MEMCONF:   cfg_q.memconf <= bus_wr.data;
          DMAWPD:    cfg_q.dmawpdev <= bus_wr.data[1:0];
          INTMASK:   cfg_q.intmask <= bus_wr.data;
          CACHECONF: cfg_q.cacheconf <= bus_wr.data[3:0];
          default:   ;
        endcase
      end
      // 7FFD wins over a loader write to the same register
      if (p7ffd_wr)
      begin
        cfg_q.memconf[0] <= din[4];  // rom select
        if (lock_mode3)
          page_q.page3 <= {2'b00, din[5], din[7:6], din[2:0]};  // 1M mode
        else
          page_q.page3 <= {3'b000, lock128 ? 2'b00 : din[7:6], din[2:0]};
      end
    end
  end

  // 48K lock from din5 outside mode 3
  always_ff @(posedge clk)
  begin
    if (rst)
      lock48 <= 1'b0;
    else if (p7ffd_wr && !lock_mode3)
      lock48 <= din[5];
  end

  assign xt_page = page_q;
  assign sys_cfg = cfg_q;

  always_comb
  begin
    video_wr.valid = bus_wr.valid && is_video(bus_wr.idx);
    video_wr.idx   = bus_wr.idx;
    video_wr.data  = bus_wr.data;
  end

endmodule

`default_nettype wire

//--- logic/reg_bus_arbiter.sv
// register bus arbiter, fixed CPU priority over the register loader
`default_nettype none

module reg_bus_arbiter import zports_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  reg_wr_t cpu_wr,
  input  logic    loader_req,
  input  reg_wr_t loader_wr,
  output reg_wr_t bus_wr,
  output logic    loader_ack
);

  logic [STALL_W-1:0] stall_cnt;  // cycles the loader has waited

  // CPU strobe cannot wait, loader gets the slot otherwise
  assign loader_ack = loader_req && !cpu_wr.valid;

  always_comb
  begin
    if (cpu_wr.valid)
    begin
      bus_wr = cpu_wr;
    end
    else
    begin
      bus_wr.valid = loader_req;
      bus_wr.idx   = loader_wr.idx;
      bus_wr.data  = loader_wr.data;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      stall_cnt <= '0;
    else if (!loader_req || loader_ack)
      stall_cnt <= '0;
    else if (stall_cnt != '1)
      stall_cnt <= stall_cnt + 1'b1;  // saturates
  end

endmodule

`default_nettype wire

//--- logic/port_decoder.sv
// CPU port address decode, register-bus write request, 7FFD and beeper strobes
`default_nettype none

module port_decoder import zports_pkg::*; (
  input  port_addr_t a,
  input  byte_t      din,
  input  logic       iord_s,
  input  logic       iowr_s,
  output port_sel_e  port_sel,
  output reg_wr_t    cpu_wr,
  output logic       p7ffd_try,
  output logic       beeper_wr,
  output logic       porthit
);

  logic io_wr;

  // a write strobe only counts outside a read cycle
  assign io_wr = iowr_s && !iord_s;

  always_comb
  begin
    case ({1'b0, a[7:0]})
      PORT_FE:    port_sel = PORT_FE;
      PORT_FD:    port_sel = PORT_FD;
      PORT_XT:    port_sel = PORT_XT;
      PORT_SDCFG: port_sel = PORT_SDCFG;
      PORT_SDDAT: port_sel = PORT_SDDAT;
      default:    port_sel = PORT_NONE;
    endcase
  end

  assign porthit = (port_sel != PORT_NONE);

  // #nnAF window write, index from high byte
  always_comb
  begin
    cpu_wr.valid = io_wr && (port_sel == PORT_XT);
    cpu_wr.idx   = xt_reg_e'(a[15:8]);
    cpu_wr.data  = din;
  end

  assign p7ffd_try = io_wr && (port_sel == PORT_FD) && !a[15];  // a15 high is AY
  assign beeper_wr = io_wr && (port_sel == PORT_FE);

endmodule

`default_nettype wire

//--- logic/zports_pkg.sv
// port numbers, register indices, bus structs and reset values for the port block
`default_nettype none

package zports_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] port_addr_t;

  // low address byte decode, bit 8 keeps PORT_NONE apart
  typedef enum logic [8:0] {
    PORT_FE    = 9'h0FE,
    PORT_FD    = 9'h0FD,
    PORT_XT    = 9'h0AF,
    PORT_SDCFG = 9'h077,
    PORT_SDDAT = 9'h057,
    PORT_NONE  = 9'h100
  } port_sel_e;

  // #nnAF register window, index is the high address byte
  typedef enum logic [7:0] {
    VCONF     = 8'h00,
    VPAGE     = 8'h01,
    GXOFFSL   = 8'h02,
    GXOFFSH   = 8'h03,
    GYOFFSL   = 8'h04,
    GYOFFSH   = 8'h05,
    TSCONF    = 8'h06,
    PALSEL    = 8'h07,
    XBORDER   = 8'h0F,
    RAMPAGE0  = 8'h10,
    RAMPAGE1  = 8'h11,
    RAMPAGE2  = 8'h12,
    RAMPAGE3  = 8'h13,
    FMADDR    = 8'h15,
    TMPAGE    = 8'h16,
    T0GPAGE   = 8'h17,
    T1GPAGE   = 8'h18,
    SGPAGE    = 8'h19,
    SYSCONF   = 8'h20,
    MEMCONF   = 8'h21,
    HSINT     = 8'h22,
    VSINTL    = 8'h23,
    VSINTH    = 8'h24,
    DMAWPD    = 8'h25,
    INTMASK   = 8'h2A,
    CACHECONF = 8'h2B,
    T0XOFFSL  = 8'h40,
    T0XOFFSH  = 8'h41,
    T0YOFFSL  = 8'h42,
    T0YOFFSH  = 8'h43,
    T1XOFFSL  = 8'h44,
    T1XOFFSH  = 8'h45,
    T1YOFFSL  = 8'h46,
    T1YOFFSH  = 8'h47
  } xt_reg_e;

  // status register shares index 00 with VCONF, read side only
  localparam xt_reg_e XSTAT = VCONF;

  typedef struct packed {
    logic    valid;
    xt_reg_e idx;
    byte_t   data;
  } reg_wr_t;

  // one-cycle video register write, same layout as a bus write
  typedef struct packed {
    logic    valid;
    xt_reg_e idx;
    byte_t   data;
  } video_wr_t;

  typedef struct packed {
    byte_t page3;
    byte_t page2;
    byte_t page1;
    byte_t page0;
  } xt_page_t;

  typedef struct packed {
    byte_t      sysconf;
    byte_t      memconf;
    byte_t      intmask;
    logic [3:0] cacheconf;
    logic [4:0] fmaddr;
    logic [1:0] dmawpdev;
  } sys_cfg_t;

  typedef struct packed {
    logic sd_cs_n;
    logic sd2_cs_n;
    logic spi_mode;
  } spi_ctrl_t;

  localparam xt_page_t RST_PAGE = '{page3: 8'h00, page2: 8'h02, page1: 8'h05, page0: 8'h00};
  localparam byte_t RST_MEMCONF = 8'h04;  // no map
  localparam byte_t RST_INTMASK = 8'h01;  // frame int only

  localparam sys_cfg_t RST_SYS_CFG = '{
    sysconf:   8'h00,
    memconf:   RST_MEMCONF,
    intmask:   RST_INTMASK,
    cacheconf: 4'h0,
    fmaddr:    5'h00,
    dmawpdev:  2'b00
  };

  localparam logic [1:0] MEMCONF_LOCK_MODE3 = 2'b11;  // memconf[7:6]

  localparam int STALL_W = 3;  // loader wait counter width

endpackage

`default_nettype wire
